//--- source/tracker_pkg.sv
package tracker_pkg;

  // ==============================
  // widths
  // ==============================
  localparam int X_W = 11;
  localparam int Y_W = 10;
  localparam int CHAN_W = 8;
  // pixel count per frame and the widest per-frame coordinate sum
  localparam int COUNT_W = 24;
  localparam int ACC_W = COUNT_W + X_W;

  // ==============================
  // pixel word, two views
  // ==============================
  typedef struct packed {
    logic [4:0] red;
    logic [5:0] green;
    logic [4:0] blue;
  } rgb565_t;

  // camera sends the high byte first
  typedef struct packed {
    logic [7:0] hi_byte;
    logic [7:0] lo_byte;
  } cam_bytes_t;

  typedef union packed {
    rgb565_t    rgb;
    cam_bytes_t bytes;
  } pixel_word_u;

  // ==============================
  // stage types
  // ==============================
  typedef struct packed {
    logic [X_W-1:0] x;
    logic [Y_W-1:0] y;
  } coord_t;

  typedef struct packed {
    logic        valid;
    logic        frame_end;
    coord_t      coord;
    pixel_word_u word;
  } raw_pixel_t;

  typedef struct packed {
    logic              valid;
    logic              frame_end;
    coord_t            coord;
    logic [CHAN_W-1:0] r;
    logic [CHAN_W-1:0] g;
    logic [CHAN_W-1:0] b;
    logic [CHAN_W-1:0] y;
    logic [CHAN_W-1:0] cr;
    logic [CHAN_W-1:0] cb;
  } color_pixel_t;

  typedef struct packed {
    logic   valid;
    logic   frame_end;
    coord_t coord;
    logic   mask;
  } mask_pixel_t;

  typedef struct packed {
    logic [2:0]        channel_sel;
    logic [CHAN_W-1:0] lower;
    logic [CHAN_W-1:0] upper;
  } mask_cfg_t;

  // frame totals from the accumulator to the divider
  typedef struct packed {
    logic               go;
    logic [ACC_W-1:0]   sum_x;
    logic [ACC_W-1:0]   sum_y;
    logic [COUNT_W-1:0] count;
  } sums_t;

  typedef struct packed {
    coord_t             coord;
    logic [COUNT_W-1:0] count;
  } centroid_t;

  // ==============================
  // channel codes, 3 and 7 give zero
  // ==============================
  localparam logic [2:0] CH_GREEN = 3'd0;
  localparam logic [2:0] CH_RED = 3'd1;
  localparam logic [2:0] CH_BLUE = 3'd2;
  localparam logic [2:0] CH_LUMA = 3'd4;
  localparam logic [2:0] CH_CR = 3'd5;
  localparam logic [2:0] CH_CB = 3'd6;

  // BT.601 weights scaled by 256
  localparam int Y_R = 66;
  localparam int Y_G = 129;
  localparam int Y_B = 25;
  localparam int CR_R = 112;
  localparam int CR_G = -94;
  localparam int CR_B = -18;
  localparam int CB_R = -38;
  localparam int CB_G = -74;
  localparam int CB_B = 112;
  localparam int Y_OFFSET = 16;
  localparam int C_OFFSET = 128;

endpackage

//--- source/pixel_assembler.sv
`timescale 1ns/1ps

module pixel_assembler (
  input  logic                    clk_camera,
  input  logic                    recent_reset,
  input  logic [7:0]              cam_data_i,
  input  logic                    cam_pclk_i,
  input  logic                    cam_hsync_i,
  input  logic                    cam_vsync_i,
  output tracker_pkg::raw_pixel_t pix_o
);
  import tracker_pkg::*;

  // two-flop synchronizers, index 1 is the settled copy
  logic [1:0][7:0] data_sync;
  logic [1:0]      pclk_sync;
  logic [1:0]      hsync_sync;
  logic [1:0]      vsync_sync;

  // previous settled values for edge detection
  logic pclk_q;
  logic hsync_q;
  logic vsync_q;

  logic pclk_rise;
  logic hsync_fall;
  logic vsync_rise;
  logic take_byte;

  // high while waiting for the low byte of a pixel
  logic   lo_phase;
  coord_t pos;

  always_ff @(posedge clk_camera) begin
    data_sync  <= {data_sync[0], cam_data_i};
    pclk_sync  <= {pclk_sync[0], cam_pclk_i};
    hsync_sync <= {hsync_sync[0], cam_hsync_i};
    vsync_sync <= {vsync_sync[0], cam_vsync_i};
  end

  assign pclk_rise  = pclk_sync[1] & ~pclk_q;
  assign hsync_fall = hsync_q & ~hsync_sync[1];
  assign vsync_rise = vsync_sync[1] & ~vsync_q;
  // bytes only count inside an active line outside vertical sync
  assign take_byte  = pclk_rise & hsync_sync[1] & ~vsync_sync[1];

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      pclk_q          <= 1'b0;
      hsync_q         <= 1'b0;
      vsync_q         <= 1'b0;
      lo_phase        <= 1'b0;
      pos             <= '0;
      pix_o.valid     <= 1'b0;
      pix_o.frame_end <= 1'b0;
    end else begin
      pclk_q          <= pclk_sync[1];
      hsync_q         <= hsync_sync[1];
      vsync_q         <= vsync_sync[1];
      pix_o.valid     <= 1'b0;
      // frame end one cycle after the settled vsync rise
      pix_o.frame_end <= vsync_rise;
      if (vsync_sync[1]) begin
        pos      <= '0;
        lo_phase <= 1'b0;
      end else if (hsync_fall) begin
        // next line starts at x zero
        pos.x    <= '0;
        pos.y    <= pos.y + 1'b1;
        lo_phase <= 1'b0;
      end else if (take_byte) begin
        if (!lo_phase) begin
          pix_o.word.bytes.hi_byte <= data_sync[1];
        end else begin
          // second byte completes the pixel
          pix_o.word.bytes.lo_byte <= data_sync[1];
          pix_o.coord              <= pos;
          pix_o.valid              <= 1'b1;
          pos.x                    <= pos.x + 1'b1;
        end
        lo_phase <= ~lo_phase;
      end
    end
  end

  // pixels are only taken with vsync low, the frame end only on its rise
  a_item_exclusive : assert property (@(posedge clk_camera) disable iff (recent_reset)
    !(pix_o.valid && pix_o.frame_end));

endmodule

//--- source/color_space_convert.sv
`timescale 1ns/1ps

module color_space_convert (
  input  logic                      clk_camera,
  input  logic                      recent_reset,
  input  tracker_pkg::raw_pixel_t   pix_i,
  output tracker_pkg::color_pixel_t pix_o
);
  import tracker_pkg::*;

  localparam int PROD_W = 18;
  localparam int SUM_W = 20;
  localparam logic signed [SUM_W-1:0] ROUND = 128;

  // rows y, cr, cb; columns r, g, b
  localparam int COEF [3][3] = '{'{Y_R, Y_G, Y_B}, '{CR_R, CR_G, CR_B}, '{CB_R, CB_G, CB_B}};
  localparam int OFFSET [3] = '{Y_OFFSET, C_OFFSET, C_OFFSET};

  logic [CHAN_W-1:0]        rgb8 [3];
  logic                     s1_valid;
  logic                     s1_frame_end;
  coord_t                   s1_coord;
  logic [CHAN_W-1:0]        s1_rgb [3];
  logic signed [PROD_W-1:0] prod [3][3];
  logic signed [SUM_W-1:0]  level [3];
  logic [CHAN_W-1:0]        ycc [3];

  // 565 fields padded with zeros at the bottom
  always_comb begin
    rgb8[0] = {pix_i.word.rgb.red, 3'b000};
    rgb8[1] = {pix_i.word.rgb.green, 2'b00};
    rgb8[2] = {pix_i.word.rgb.blue, 3'b000};
  end

  // ==============================
  // step one, weighted products
  // ==============================
  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      s1_valid     <= 1'b0;
      s1_frame_end <= 1'b0;
    end else begin
      s1_valid     <= pix_i.valid;
      s1_frame_end <= pix_i.frame_end;
    end
  end

  always_ff @(posedge clk_camera) begin
    s1_coord <= pix_i.coord;
    s1_rgb   <= rgb8;
    for (int i = 0; i < 3; i++) begin
      for (int j = 0; j < 3; j++) begin
        prod[i][j] <= PROD_W'($signed({1'b0, rgb8[j]}) * COEF[i][j]);
      end
    end
  end

  // ==============================
  // step two, sum, round, clamp
  // ==============================
  always_comb begin
    for (int i = 0; i < 3; i++) begin
      level[i] = ((prod[i][0] + prod[i][1] + prod[i][2] + ROUND) >>> 8) + SUM_W'(OFFSET[i]);
      if (level[i] < 0) begin
        ycc[i] = '0;
      end else if (level[i] > 255) begin
        ycc[i] = '1;
      end else begin
        ycc[i] = level[i][CHAN_W-1:0];
      end
    end
  end

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      pix_o.valid     <= 1'b0;
      pix_o.frame_end <= 1'b0;
    end else begin
      pix_o.valid     <= s1_valid;
      pix_o.frame_end <= s1_frame_end;
      pix_o.coord     <= s1_coord;
      pix_o.r         <= s1_rgb[0];
      pix_o.g         <= s1_rgb[1];
      pix_o.b         <= s1_rgb[2];
      pix_o.y         <= ycc[0];
      pix_o.cr        <= ycc[1];
      pix_o.cb        <= ycc[2];
    end
  end

endmodule

//--- source/mask_threshold.sv
`timescale 1ns/1ps

module mask_threshold (
  input  logic                      clk_camera,
  input  logic                      recent_reset,
  input  tracker_pkg::color_pixel_t pix_i,
  input  tracker_pkg::mask_cfg_t    cfg_i,
  output tracker_pkg::mask_pixel_t  pix_o
);
  import tracker_pkg::*;

  logic [CHAN_W-1:0] chan;

  // unused codes fall to zero
  always_comb begin
    case (cfg_i.channel_sel)
      CH_GREEN: chan = pix_i.g;
      CH_RED:   chan = pix_i.r;
      CH_BLUE:  chan = pix_i.b;
      CH_LUMA:  chan = pix_i.y;
      CH_CR:    chan = pix_i.cr;
      CH_CB:    chan = pix_i.cb;
      default:  chan = '0;
    endcase
  end

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      pix_o.valid     <= 1'b0;
      pix_o.frame_end <= 1'b0;
    end else begin
      pix_o.valid     <= pix_i.valid;
      pix_o.frame_end <= pix_i.frame_end;
      pix_o.coord     <= pix_i.coord;
      // inclusive window on both ends
      pix_o.mask      <= (chan >= cfg_i.lower) && (chan <= cfg_i.upper);
    end
  end

  // config from the top must describe a non-empty window while pixels flow
  a_cfg_window : assert property (@(posedge clk_camera) disable iff (recent_reset)
    pix_i.valid |-> cfg_i.lower <= cfg_i.upper);

endmodule

//--- source/mass_accumulator.sv
`timescale 1ns/1ps

module mass_accumulator #(
  parameter int H_ACTIVE = 1280,
  parameter int V_ACTIVE = 720
) (
  input  logic                     clk_camera,
  input  logic                     recent_reset,
  input  tracker_pkg::mask_pixel_t pix_i,
  output tracker_pkg::sums_t       sums_o
);
  import tracker_pkg::*;

  // enough bits for a full frame of hits at the widest coordinate
  localparam int CNT_BITS = $clog2(H_ACTIVE * V_ACTIVE + 1);
  localparam int SUM_BITS = CNT_BITS + $clog2(H_ACTIVE > V_ACTIVE ? H_ACTIVE : V_ACTIVE);

  logic [SUM_BITS-1:0] acc_x;
  logic [SUM_BITS-1:0] acc_y;
  logic [CNT_BITS-1:0] acc_n;

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      acc_x  <= '0;
      acc_y  <= '0;
      acc_n  <= '0;
      sums_o <= '0;
    end else begin
      sums_o.go <= pix_i.frame_end;
      if (pix_i.frame_end) begin
        // hand totals over and clear for the next frame in the same cycle
        sums_o.sum_x <= ACC_W'(acc_x);
        sums_o.sum_y <= ACC_W'(acc_y);
        sums_o.count <= COUNT_W'(acc_n);
        acc_x        <= '0;
        acc_y        <= '0;
        acc_n        <= '0;
      end else if (pix_i.valid && pix_i.mask) begin
        acc_x <= acc_x + SUM_BITS'(pix_i.coord.x);
        acc_y <= acc_y + SUM_BITS'(pix_i.coord.y);
        acc_n <= acc_n + 1'b1;
      end
    end
  end

  // a frame never has more hits than active pixels
  a_count_bound : assert property (@(posedge clk_camera) disable iff (recent_reset)
    (pix_i.valid && pix_i.mask) |-> acc_n < H_ACTIVE * V_ACTIVE);

endmodule

//--- source/centroid_divider.sv
`timescale 1ns/1ps

module centroid_divider #(
  parameter int H_ACTIVE = 1280,
  parameter int V_ACTIVE = 720
) (
  input  logic                   clk_camera,
  input  logic                   recent_reset,
  input  tracker_pkg::sums_t     sums_i,
  output tracker_pkg::centroid_t centroid_o,
  output logic                   com_valid_o
);
  import tracker_pkg::*;

  localparam int CNT_BITS = $clog2(H_ACTIVE * V_ACTIVE + 1);
  localparam int SUM_BITS = CNT_BITS + $clog2(H_ACTIVE > V_ACTIVE ? H_ACTIVE : V_ACTIVE);
  localparam int STEP_W = $clog2(SUM_BITS + 1);

  typedef enum logic [1:0] {S_IDLE, S_DIV_X, S_DIV_Y} state_t;

  state_t              state;
  logic [STEP_W-1:0]   step;
  logic                start;
  logic                div_done;
  logic [CNT_BITS-1:0] divisor;
  logic [SUM_BITS-1:0] dividend_y;
  // dividend shifts out at the top while quotient bits shift in
  logic [SUM_BITS-1:0] quot;
  logic [CNT_BITS-1:0] rem;
  logic [CNT_BITS:0]   trial;
  logic [CNT_BITS:0]   diff;
  logic                fits;
  logic [X_W-1:0]      quot_x;

  // an empty frame is dropped here, a go while busy too
  assign start    = (state == S_IDLE) && sums_i.go && (sums_i.count != '0);
  assign div_done = (step == STEP_W'(SUM_BITS));
  assign trial    = {rem, quot[SUM_BITS-1]};
  assign diff     = trial - {1'b0, divisor};
  assign fits     = trial >= {1'b0, divisor};

  // ==============================
  // control
  // ==============================
  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      state       <= S_IDLE;
      step        <= '0;
      com_valid_o <= 1'b0;
      centroid_o  <= '0;
    end else begin
      com_valid_o <= 1'b0;
      step        <= (start || div_done) ? '0 : step + 1'b1;
      case (state)
        S_IDLE: begin
          if (start) begin
            state <= S_DIV_X;
          end
        end
        S_DIV_X: begin
          if (div_done) begin
            state <= S_DIV_Y;
          end
        end
        default: begin
          if (div_done) begin
            state                <= S_IDLE;
            centroid_o.coord.x   <= quot_x;
            centroid_o.coord.y   <= quot[Y_W-1:0];
            centroid_o.count     <= COUNT_W'(divisor);
            com_valid_o          <= 1'b1;
          end
        end
      endcase
    end
  end

  // ==============================
  // datapath, one quotient bit per cycle
  // ==============================
  always_ff @(posedge clk_camera) begin
    if (start) begin
      divisor    <= CNT_BITS'(sums_i.count);
      dividend_y <= SUM_BITS'(sums_i.sum_y);
      quot       <= SUM_BITS'(sums_i.sum_x);
      rem        <= '0;
    end else if (state != S_IDLE && !div_done) begin
      rem  <= fits ? diff[CNT_BITS-1:0] : trial[CNT_BITS-1:0];
      quot <= {quot[SUM_BITS-2:0], fits};
    end else if (state == S_DIV_X && div_done) begin
      // x finished, reload for y
      quot_x <= quot[X_W-1:0];
      quot   <= dividend_y;
      rem    <= '0;
    end
  end

  // mean coordinates stay on screen when the accumulated sums are consistent
  a_mean_x : assert property (@(posedge clk_camera) disable iff (recent_reset)
    (state == S_DIV_X && div_done) |-> quot < H_ACTIVE);
  a_mean_y : assert property (@(posedge clk_camera) disable iff (recent_reset)
    (state == S_DIV_Y && div_done) |-> quot < V_ACTIVE);

endmodule

//--- source/centroid_tracker.sv
`timescale 1ns/1ps

module centroid_tracker #(
  parameter int H_ACTIVE = 1280,
  parameter int V_ACTIVE = 720
) (
  input  logic                   clk_camera,
  input  logic                   recent_reset,
  input  logic [7:0]             cam_data_i,
  input  logic                   cam_pclk_i,
  input  logic                   cam_hsync_i,
  input  logic                   cam_vsync_i,
  input  tracker_pkg::mask_cfg_t mask_cfg_i,
  output tracker_pkg::centroid_t centroid_o,
  output logic                   com_valid_o
);
  import tracker_pkg::*;

  raw_pixel_t   raw_pix;
  color_pixel_t color_pix;
  mask_pixel_t  mask_pix;
  sums_t        sums;

  // ==============================
  // camera bus to pixels
  // ==============================
  pixel_assembler u_pixel_assembler (
    .clk_camera   (clk_camera),
    .recent_reset (recent_reset),
    .cam_data_i   (cam_data_i),
    .cam_pclk_i   (cam_pclk_i),
    .cam_hsync_i  (cam_hsync_i),
    .cam_vsync_i  (cam_vsync_i),
    .pix_o        (raw_pix)
  );

  color_space_convert u_color_space_convert (
    .clk_camera   (clk_camera),
    .recent_reset (recent_reset),
    .pix_i        (raw_pix),
    .pix_o        (color_pix)
  );

  mask_threshold u_mask_threshold (
    .clk_camera   (clk_camera),
    .recent_reset (recent_reset),
    .pix_i        (color_pix),
    .cfg_i        (mask_cfg_i),
    .pix_o        (mask_pix)
  );

  // ==============================
  // center of mass
  // ==============================
  mass_accumulator #(
    .H_ACTIVE (H_ACTIVE),
    .V_ACTIVE (V_ACTIVE)
  ) u_mass_accumulator (
    .clk_camera   (clk_camera),
    .recent_reset (recent_reset),
    .pix_i        (mask_pix),
    .sums_o       (sums)
  );

  centroid_divider #(
    .H_ACTIVE (H_ACTIVE),
    .V_ACTIVE (V_ACTIVE)
  ) u_centroid_divider (
    .clk_camera   (clk_camera),
    .recent_reset (recent_reset),
    .sums_i       (sums),
    .centroid_o   (centroid_o),
    .com_valid_o  (com_valid_o)
  );

endmodule

//--- sim/tb_reference.svh
`ifndef TB_REFERENCE_SVH
`define TB_REFERENCE_SVH

// reference model pulled into the testbench module body

// ==============================
// color conversion
// ==============================
// 8-bit channel from a 565 field with zero low bits
function automatic int expand(input int field, input int bits);
  return field << (8 - bits);
endfunction

// BT.601 weighted sum with rounding, offset and clamp to 0..255
function automatic int weigh(input int kr, input int kg, input int kb,
                             input int r, input int g, input int b, input int offset);
  int level;
  level = ((kr * r + kg * g + kb * b + 128) >>> 8) + offset;
  if (level < 0) begin
    return 0;
  end
  if (level > 255) begin
    return 255;
  end
  return level;
endfunction

// value of the channel picked by sel where unused codes give zero
function automatic int channel_of(input logic [15:0] px, input logic [2:0] sel);
  int r;
  int g;
  int b;
  r = expand(px[15:11], 5);
  g = expand(px[10:5], 6);
  b = expand(px[4:0], 5);
  case (sel)
    3'd0: return g;
    3'd1: return r;
    3'd2: return b;
    3'd4: return weigh(66, 129, 25, r, g, b, 16);
    3'd5: return weigh(112, -94, -18, r, g, b, 128);
    3'd6: return weigh(-38, -74, 112, r, g, b, 128);
    default: return 0;
  endcase
endfunction

// inclusive window on the selected channel
function automatic bit passes(input logic [15:0] px, input mask_cfg_t cfg);
  int c;
  c = channel_of(px, cfg.channel_sel);
  return (c >= cfg.lower) && (c <= cfg.upper);
endfunction

// ==============================
// center of mass of the stored frame
// ==============================
function automatic centroid_t frame_centroid(input mask_cfg_t cfg);
  longint sx;
  longint sy;
  longint n;
  centroid_t c;
  sx = 0;
  sy = 0;
  n = 0;
  c = '0;
  for (int yy = 0; yy < V_ACTIVE; yy++) begin
    for (int xx = 0; xx < H_ACTIVE; xx++) begin
      if (passes(frame_pix[yy * H_ACTIVE + xx], cfg)) begin
        sx += xx;
        sy += yy;
        n++;
      end
    end
  end
  // floor mean with zero left in place for an empty frame
  if (n > 0) begin
    c.coord.x = X_W'(sx / n);
    c.coord.y = Y_W'(sy / n);
    c.count   = COUNT_W'(n);
  end
  return c;
endfunction

task automatic check_value(input logic [63:0] got, input logic [63:0] exp, input string what);
  if (got !== exp) begin
    err_count++;
    $display("CHECK FAILED at %0d ns: %s, got %0d, expected %0d", $time, what, got, exp);
  end
endtask

`endif

//--- sim/tb_centroid_tracker.sv
`timescale 1ns/1ps

module tb_centroid_tracker;
  import tracker_pkg::*;

  localparam int H_ACTIVE = 16;
  localparam int V_ACTIVE = 8;
  localparam int FRAME_PIX = H_ACTIVE * V_ACTIVE;
  // two bytes per pixel, four clocks per byte, four clocks of line gap
  localparam int FRAME_CYCLES = V_ACTIVE * (8 * H_ACTIVE + 4) + 4;
  localparam int NUM_FRAMES = 8;
  localparam int CYCLE_LIMIT = NUM_FRAMES * FRAME_CYCLES + 1000;
  // low-green rectangle for the green test
  localparam int RX0 = 3;
  localparam int RX1 = 9;
  localparam int RY0 = 2;
  localparam int RY1 = 5;

  logic       clk_camera = 1'b0;
  logic       recent_reset;
  logic [7:0] cam_data;
  logic       cam_pclk;
  logic       cam_hsync;
  logic       cam_vsync;
  mask_cfg_t  mask_cfg;
  centroid_t  centroid;
  logic       com_valid;

  logic [15:0] frame_pix [FRAME_PIX];
  centroid_t   expect_q [$];
  centroid_t   last_result = '0;
  integer      seed = 10;
  int          err_count = 0;
  int          err_mark = 0;
  int          pulse_count = 0;
  int          cycle_count = 0;
  int          tests_passed = 0;
  int          tests_failed = 0;

  `include "tb_reference.svh"

  centroid_tracker #(
    .H_ACTIVE (H_ACTIVE),
    .V_ACTIVE (V_ACTIVE)
  ) DUT (
    .clk_camera   (clk_camera),
    .recent_reset (recent_reset),
    .cam_data_i   (cam_data),
    .cam_pclk_i   (cam_pclk),
    .cam_hsync_i  (cam_hsync),
    .cam_vsync_i  (cam_vsync),
    .mask_cfg_i   (mask_cfg),
    .centroid_o   (centroid),
    .com_valid_o  (com_valid)
  );

  always #10 clk_camera = ~clk_camera;

  // watchdog
  always @(posedge clk_camera) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles, the DUT stopped delivering results", cycle_count);
      $display("Test FAILED");
      $finish;
    end
  end

  // ==============================
  // result comparison
  // ==============================
  always @(negedge clk_camera) begin
    if (!recent_reset && com_valid) begin
      pulse_count++;
      if (expect_q.size() == 0) begin
        err_count++;
        $display("Unexpected com_valid_o pulse at %0d ns with no frame result pending", $time);
      end else begin
        last_result = expect_q.pop_front();
        check_value(centroid.coord.x, last_result.coord.x, "centroid x");
        check_value(centroid.coord.y, last_result.coord.y, "centroid y");
        check_value(centroid.count, last_result.count, "pixel count");
      end
    end
  end

  // one byte per camera pclk cycle at a quarter of clk_camera
  task automatic send_byte(input logic [7:0] value);
    cam_data = value;
    cam_pclk = 1'b0;
    repeat (2) @(negedge clk_camera);
    cam_pclk = 1'b1;
    repeat (2) @(negedge clk_camera);
  endtask

  task automatic drive_frame();
    for (int yy = 0; yy < V_ACTIVE; yy++) begin
      cam_hsync = 1'b1;
      for (int xx = 0; xx < H_ACTIVE; xx++) begin
        send_byte(frame_pix[yy * H_ACTIVE + xx][15:8]);
        send_byte(frame_pix[yy * H_ACTIVE + xx][7:0]);
      end
      // line gap with hsync low
      cam_pclk  = 1'b0;
      cam_hsync = 1'b0;
      repeat (4) @(negedge clk_camera);
    end
    // vsync pulse closes the frame
    cam_vsync = 1'b1;
    repeat (4) @(negedge clk_camera);
    cam_vsync = 1'b0;
  endtask

  task automatic random_fill();
    for (int i = 0; i < FRAME_PIX; i++) begin
      frame_pix[i] = 16'($random(seed));
    end
  endtask

  // green field 4 inside the rectangle and 63 outside
  // red and blue follow the address
  task automatic rectangle_fill();
    bit inside_rect;
    for (int i = 0; i < FRAME_PIX; i++) begin
      inside_rect = (i % H_ACTIVE >= RX0) && (i % H_ACTIVE <= RX1) &&
                    (i / H_ACTIVE >= RY0) && (i / H_ACTIVE <= RY1);
      frame_pix[i] = {i[4:0], inside_rect ? 6'd4 : 6'd63, 5'(i >> 2)};
    end
  endtask

  task automatic run_frame(input mask_cfg_t cfg);
    centroid_t exp_c;
    mask_cfg = cfg;
    exp_c = frame_centroid(cfg);
    // an empty frame gives no result
    if (exp_c.count != 0) begin
      expect_q.push_back(exp_c);
    end
    drive_frame();
  endtask

  task automatic wait_drained();
    while (expect_q.size() != 0) begin
      @(negedge clk_camera);
    end
  endtask

  task automatic finish_test(input string name);
    if (err_count == err_mark) begin
      tests_passed++;
      $display("[%0d ns] pass: %s", $time, name);
    end else begin
      tests_failed++;
      $display("[%0d ns] fail: %s", $time, name);
    end
    err_mark = err_count;
  endtask

  // ==============================
  // test sequence
  // ==============================
  initial begin
    mask_cfg_t chan_cfg [3];
    centroid_t prev;
    int        seen;
    chan_cfg[0]  = mask_cfg_t'{CH_LUMA, 8'd100, 8'd200};
    chan_cfg[1]  = mask_cfg_t'{CH_CR, 8'd120, 8'd160};
    chan_cfg[2]  = mask_cfg_t'{CH_CB, 8'd100, 8'd140};
    recent_reset = 1'b1;
    cam_data     = '0;
    cam_pclk     = 1'b0;
    cam_hsync    = 1'b0;
    cam_vsync    = 1'b0;
    mask_cfg     = mask_cfg_t'{CH_GREEN, 8'd0, 8'd255};
    repeat (4) @(negedge clk_camera);
    recent_reset = 1'b0;

    @(negedge clk_camera);
    check_value(com_valid, 0, "com_valid_o after reset");
    check_value(centroid, 0, "centroid_o after reset");
    finish_test("reset state");

    // rectangle mean is the midpoint of its bounds
    rectangle_fill();
    run_frame(mask_cfg_t'{CH_GREEN, 8'd0, 8'd64});
    wait_drained();
    check_value(centroid.coord.x, (RX0 + RX1) / 2, "rectangle mean x");
    check_value(centroid.coord.y, (RY0 + RY1) / 2, "rectangle mean y");
    check_value(centroid.count, (RX1 - RX0 + 1) * (RY1 - RY0 + 1), "rectangle count");
    finish_test("green rectangle");

    for (int k = 0; k < 3; k++) begin
      random_fill();
      run_frame(chan_cfg[k]);
      wait_drained();
    end
    finish_test("luma, cr and cb channels");

    // code 3 reads as zero so nothing passes
    prev = last_result;
    seen = pulse_count;
    random_fill();
    run_frame(mask_cfg_t'{3'd3, 8'd1, 8'd255});
    // well beyond a full x and y divide
    repeat (64) @(negedge clk_camera);
    check_value(pulse_count, seen, "pulses after empty frame");
    check_value(centroid, prev, "centroid_o held over empty frame");
    random_fill();
    run_frame(chan_cfg[0]);
    wait_drained();
    finish_test("empty frame holds result");

    random_fill();
    run_frame(mask_cfg_t'{CH_RED, 8'd0, 8'd127});
    random_fill();
    run_frame(mask_cfg_t'{CH_RED, 8'd0, 8'd127});
    wait_drained();
    finish_test("back-to-back frames");

    $display("%0d tests passed, %0d tests failed, %0d check errors",
             tests_passed, tests_failed, err_count);
    if (err_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

//--- build.f
+incdir+sim
source/tracker_pkg.sv
source/pixel_assembler.sv
source/color_space_convert.sv
source/mask_threshold.sv
source/mass_accumulator.sv
source/centroid_divider.sv
source/centroid_tracker.sv
sim/tb_centroid_tracker.sv

//--- Bender.yml
package:
  name: centroid_tracker

sources:
  - files:
      - source/tracker_pkg.sv
      - source/pixel_assembler.sv
      - source/color_space_convert.sv
      - source/mask_threshold.sv
      - source/mass_accumulator.sv
      - source/centroid_divider.sv
      - source/centroid_tracker.sv
  - target: test
    include_dirs:
      - sim
    files:
      - sim/tb_centroid_tracker.sv
